/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - hw
    files:
      - hw/dcache_pkg.sv
      - hw/mem_bus_if.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_array.sv
      - hw/axi_mem_port.sv
      - hw/dcache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clock_gen.sv
      - test/axi_mem_model.sv
      - test/dcache_checker.sv
      - test/dcache_tb.sv

/* compile.f */
+incdir+hw
hw/dcache_pkg.sv
hw/mem_bus_if.sv
hw/dcache_ctrl.sv
hw/dcache_array.sv
hw/axi_mem_port.sv
hw/dcache_top.sv
test/tb_clock_gen.sv
test/axi_mem_model.sv
test/dcache_checker.sv
test/dcache_tb.sv

/* hw/axi_mem_port.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module axi_mem_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  arready,
    input  logic [`DC_DATA_W-1:0] rdata,
    input  logic                  rvalid,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic [`DC_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    output logic [`DC_ADDR_W-1:0] awaddr,
    output logic                  awvalid,
    output logic [`DC_DATA_W-1:0] wdata,
    output logic                  wvalid,
    mem_bus_if.port               mem
);
    import dcache_pkg::*;

    logic rd_pend;
    logic wr_pend;
    logic rd_chain;
    logic b_seen;

    assign b_seen          = bvalid && wr_pend;
    assign mem.bvalid_seen = b_seen;
    assign mem.rdata       = rdata;
    // a chained read finishes the request, not its write response
    assign mem.done        = (rvalid && rd_pend) || (b_seen && !rd_chain);

    always_ff @(posedge clk) begin
        if (mem.start) begin
            araddr <= mem.rd_addr;
            awaddr <= mem.wb_addr;
            wdata  <= mem.wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            arvalid  <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            rd_pend  <= 1'b0;
            wr_pend  <= 1'b0;
            rd_chain <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;
            end
            if (rvalid && rd_pend) begin
                rd_pend <= 1'b0;
            end
            if (b_seen) begin
                wr_pend <= 1'b0;
                if (rd_chain) begin
                    arvalid  <= 1'b1;
                    rd_pend  <= 1'b1;
                    rd_chain <= 1'b0;
                end
            end
            if (mem.start) begin
                case (mem.kind)
                    mem_refill: begin
                        arvalid <= 1'b1;
                        rd_pend <= 1'b1;
                    end
                    mem_writeback, mem_writeback_refill: begin
                        awvalid  <= 1'b1;
                        wvalid   <= 1'b1;
                        wr_pend  <= 1'b1;
                        rd_chain <= (mem.kind == mem_writeback_refill);
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* hw/dcache_array.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_array (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  cpu_we,
    input  logic [`DC_ADDR_W-1:0] cpu_addr,
    input  logic [`DC_DATA_W-1:0] cpu_wdata,
    input  logic                  rd_line,
    input  logic                  wr_line,
    input  logic                  fill,
    input  logic                  flush_step,
    input  logic                  clean_line,
    input  logic                  flushing,
    output logic                  hit,
    output logic                  miss,
    output logic                  dirty,
    output logic                  flush_done,
    output logic [`DC_DATA_W-1:0] cpu_rdata,
    mem_bus_if.line               mem
);
    import dcache_pkg::*;

    logic [`DC_ADDR_W-1:0] req_addr;
    logic [`DC_DATA_W-1:0] req_wdata;
    logic                  req_we;
    logic [TAG_W-1:0]      tag_mem  [`DC_LINES];
    logic [`DC_DATA_W-1:0] data_mem [`DC_LINES];
    logic [`DC_LINES-1:0]  valid_bits;
    logic [`DC_LINES-1:0]  dirty_bits;
    logic [INDEX_W-1:0]    idx;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    walk_idx;
    logic                  walk_done;
    logic [INDEX_W-1:0]    sel_idx;

    assign idx     = req_addr[`DC_OFFSET_W +: INDEX_W];
    assign req_tag = req_addr[`DC_ADDR_W-1 -: TAG_W];
    // victim is the request line, or the walker line during a flush
    assign sel_idx = flushing ? walk_idx : idx;

    always_ff @(posedge clk) begin
        if (en) begin
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_we <= 1'b0;
        end else if (en) begin
            req_we <= cpu_we;
        end
    end

    assign hit        = valid_bits[idx] && (tag_mem[idx] == req_tag);
    assign miss       = !hit;
    assign dirty      = dirty_bits[sel_idx];
    assign flush_done = walk_done;
    assign cpu_rdata  = (rd_line && !req_we) ? data_mem[idx] : '0;

    assign mem.rd_addr = {req_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign mem.wb_addr = {tag_mem[sel_idx], sel_idx, {`DC_OFFSET_W{1'b0}}};
    assign mem.wb_data = data_mem[sel_idx];

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[idx]  <= req_tag;
            data_mem[idx] <= mem.rdata;
        end else if (wr_line && req_we) begin
            data_mem[idx] <= req_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (fill) begin
                valid_bits[idx] <= 1'b1;
                dirty_bits[idx] <= 1'b0;
            end
            if (wr_line && req_we) begin
                dirty_bits[idx] <= 1'b1;
            end
            // memory holds the victim once the write response is back
            if (mem.bvalid_seen) begin
                dirty_bits[sel_idx] <= 1'b0;
            end
            if (clean_line) begin
                valid_bits[walk_idx] <= 1'b0;
                dirty_bits[walk_idx] <= 1'b0;
            end
        end
    end

    // walker wraps to zero after the last line and stays done until flushing drops
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk_idx  <= '0;
            walk_done <= 1'b0;
        end else if (!flushing) begin
            walk_idx  <= '0;
            walk_done <= 1'b0;
        end else if (flush_step) begin
            if (walk_idx == INDEX_W'(`DC_LINES - 1)) begin
                walk_done <= 1'b1;
            end
            walk_idx <= walk_idx + 1'b1;
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_valid,
    input  logic    flush,
    input  logic    hit,
    input  logic    miss,
    input  logic    dirty,
    input  logic    flush_done,
    output logic    en,
    output logic    rd_line,
    output logic    wr_line,
    output logic    fill,
    output logic    flush_step,
    output logic    clean_line,
    output logic    cpu_ready,
    output logic    flushing,
    mem_bus_if.core mem
);
    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        flush_active;
    logic        flush_set;
    logic        flush_clr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // remembers that wait_mem was entered from the flush walk
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_active <= 1'b0;
        end else if (flush_set) begin
            flush_active <= 1'b1;
        end else if (flush_clr) begin
            flush_active <= 1'b0;
        end
    end

    assign flushing = flush_active;

    always_comb begin
        next_state = state;
        en         = 1'b0;
        rd_line    = 1'b0;
        wr_line    = 1'b0;
        fill       = 1'b0;
        flush_step = 1'b0;
        clean_line = 1'b0;
        cpu_ready  = 1'b0;
        flush_set  = 1'b0;
        flush_clr  = 1'b0;
        mem.start  = 1'b0;
        mem.kind   = mem_none;

        case (state)
            st_idle: begin
                // flush wins over an access in the same cycle
                if (flush) begin
                    flush_set  = 1'b1;
                    next_state = st_flush;
                end else if (cpu_valid) begin
                    en         = 1'b1;
                    next_state = st_process_request;
                end
            end

            st_process_request: begin
                if (hit) begin
                    // array qualifies both strobes with the latched write flag
                    rd_line    = 1'b1;
                    wr_line    = 1'b1;
                    cpu_ready  = 1'b1;
                    next_state = st_idle;
                end else if (miss) begin
                    mem.start  = 1'b1;
                    mem.kind   = dirty ? mem_writeback_refill : mem_refill;
                    next_state = st_wait_mem;
                end
            end

            st_wait_mem: begin
                if (mem.done) begin
                    if (flush_active) begin
                        clean_line = 1'b1;
                        flush_step = 1'b1;
                        next_state = st_flush;
                    end else begin
                        // line answers as a hit on the way back
                        fill       = 1'b1;
                        next_state = st_process_request;
                    end
                end
            end

            st_flush: begin
                if (flush_done) begin
                    cpu_ready  = 1'b1;
                    flush_clr  = 1'b1;
                    next_state = st_idle;
                end else if (dirty) begin
                    mem.start  = 1'b1;
                    mem.kind   = mem_writeback;
                    next_state = st_wait_mem;
                end else begin
                    clean_line = 1'b1;
                    flush_step = 1'b1;
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

/* hw/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address presented by the load/store unit
`define DC_ADDR_W 32

// one word per line
`define DC_DATA_W 32

// direct mapped, so this is also the number of sets
`define DC_LINES 16

// bits 1:0 select a byte inside the word and are ignored
`define DC_OFFSET_W 2

`endif

/* hw/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [1:0] {
        st_idle,
        st_process_request,
        st_wait_mem,
        st_flush
    } ctrl_state_t;

    // what the memory port has to do for one request
    typedef enum logic [1:0] {
        mem_none,
        mem_refill,
        mem_writeback,
        mem_writeback_refill
    } mem_kind_t;

    // index is addr[5:2], tag is addr[31:6]
    localparam int INDEX_W = $clog2(`DC_LINES);
    localparam int TAG_W   = `DC_ADDR_W - INDEX_W - `DC_OFFSET_W;

endpackage

/* hw/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_valid,
    input  logic                  cpu_we,
    input  logic [`DC_ADDR_W-1:0] cpu_addr,
    input  logic [`DC_DATA_W-1:0] cpu_wdata,
    input  logic                  flush,
    output logic                  cpu_ready,
    output logic [`DC_DATA_W-1:0] cpu_rdata,
    output logic                  flushing,
    output logic [`DC_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [`DC_DATA_W-1:0] rdata,
    input  logic                  rvalid,
    output logic [`DC_ADDR_W-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [`DC_DATA_W-1:0] wdata,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid
);
    logic en;
    logic hit;
    logic miss;
    logic dirty;
    logic rd_line;
    logic wr_line;
    logic fill;
    logic flush_step;
    logic clean_line;
    logic flush_done;

    mem_bus_if u_bus ();

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .flush      (flush),
        .hit        (hit),
        .miss       (miss),
        .dirty      (dirty),
        .flush_done (flush_done),
        .en         (en),
        .rd_line    (rd_line),
        .wr_line    (wr_line),
        .fill       (fill),
        .flush_step (flush_step),
        .clean_line (clean_line),
        .cpu_ready  (cpu_ready),
        .flushing   (flushing),
        .mem        (u_bus.core)
    );

    dcache_array u_array (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .rd_line    (rd_line),
        .wr_line    (wr_line),
        .fill       (fill),
        .flush_step (flush_step),
        .clean_line (clean_line),
        .flushing   (flushing),
        .hit        (hit),
        .miss       (miss),
        .dirty      (dirty),
        .flush_done (flush_done),
        .cpu_rdata  (cpu_rdata),
        .mem        (u_bus.line)
    );

    axi_mem_port u_port (
        .clk     (clk),
        .rst     (rst),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .araddr  (araddr),
        .arvalid (arvalid),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .mem     (u_bus.port)
    );

endmodule

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

interface mem_bus_if;
    import dcache_pkg::*;

    logic                  start;
    mem_kind_t             kind;
    logic [`DC_ADDR_W-1:0] rd_addr;
    logic [`DC_ADDR_W-1:0] wb_addr;
    logic [`DC_DATA_W-1:0] wb_data;
    logic                  done;
    logic                  bvalid_seen;
    logic [`DC_DATA_W-1:0] rdata;

    modport core (output start, kind, input done);
    modport line (output rd_addr, wb_addr, wb_data, input rdata, bvalid_seen);
    modport port (input start, kind, rd_addr, wb_addr, wb_data,
                  output done, bvalid_seen, rdata);

endinterface

/* test/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid
);
    // sparse store, untouched words read as address ^ 32'h5a5a_0000
    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];
    logic [31:0] rnd;
    logic        ar_fire;
    logic [31:0] ar_addr_held;
    logic [31:0] aw_addr_held;
    logic        aw_held;
    logic [31:0] w_data_held;
    logic        w_held;

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        for (int i = 0; i < store_addr.size(); i++) begin
            if (store_addr[i] == addr) begin
                return store_data[i];
            end
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        for (int i = 0; i < store_addr.size(); i++) begin
            if (store_addr[i] == addr) begin
                store_data[i] = data;
                return;
            end
        end
        store_addr.push_back(addr);
        store_data.push_back(data);
    endtask

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            arready = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            rvalid  = 1'b0;
            bvalid  = 1'b0;
            rdata   = '0;
            rnd     = SEED;
            aw_held = 1'b0;
            w_held  = 1'b0;
        end else begin
            ar_fire      = arvalid && arready;
            ar_addr_held = araddr;
            if (awvalid && awready) begin
                aw_addr_held = awaddr;
                aw_held      = 1'b1;
            end
            if (wvalid && wready) begin
                w_data_held = wdata;
                w_held      = 1'b1;
            end
            rnd = xorshift_step(rnd);
            #2;
            rvalid = 1'b0;
            bvalid = 1'b0;
            if (ar_fire) begin
                rvalid = 1'b1;
                rdata  = read_word(ar_addr_held);
            end
            // response goes out once both address and data are in
            if (aw_held && w_held) begin
                write_word(aw_addr_held, w_data_held);
                aw_held = 1'b0;
                w_held  = 1'b0;
                bvalid  = 1'b1;
            end
            // ready about three cycles in four
            arready = rnd[0] | rnd[1];
            awready = rnd[2] | rnd[3];
            wready  = rnd[4] | rnd[5];
        end
    end

endmodule

/* test/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
    input logic clk,
    input logic rst,
    input logic cpu_ready,
    input logic flushing,
    input logic arvalid,
    input logic arready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready
);
    int unsigned fail_count = 0;

    a_quiet_reset: assert property (@(posedge clk)
        (!rst || $rose(rst)) |-> !(cpu_ready || flushing || arvalid || awvalid || wvalid))
        else begin
            $error("outputs active during or right after reset");
            fail_count++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_count++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_count++;
        end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst)
        wvalid && !wready |=> wvalid)
        else begin
            $error("wvalid dropped before wready");
            fail_count++;
        end

    // end of flush only once the memory channels are quiet
    a_flush_ready: assert property (@(posedge clk) disable iff (!rst)
        cpu_ready && flushing |-> !(arvalid || awvalid || wvalid))
        else begin
            $error("cpu_ready during flush with a memory request pending");
            fail_count++;
        end

    a_flush_no_read: assert property (@(posedge clk) disable iff (!rst)
        flushing |-> !arvalid)
        else begin
            $error("read address issued during flush");
            fail_count++;
        end

endmodule

bind dcache_top dcache_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .cpu_ready (cpu_ready),
    .flushing  (flushing),
    .arvalid   (arvalid),
    .arready   (arready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready)
);

/* test/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb;
    localparam logic [31:0] SEED        = 32'ha4aa_42cd;
    localparam logic [31:0] INIT_XOR    = 32'h5a5a_0000;
    localparam int          WAIT_LIMIT  = 400;
    localparam int          FLUSH_LIMIT = 2000;

    logic                  clk;
    logic                  rst;
    logic                  cpu_valid;
    logic                  cpu_we;
    logic [`DC_ADDR_W-1:0] cpu_addr;
    logic [`DC_DATA_W-1:0] cpu_wdata;
    logic                  flush;
    logic                  cpu_ready;
    logic [`DC_DATA_W-1:0] cpu_rdata;
    logic                  flushing;
    logic [`DC_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [`DC_DATA_W-1:0] rdata;
    logic                  rvalid;
    logic [`DC_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [`DC_DATA_W-1:0] wdata;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;

    string       test_name;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rnd;
    logic [31:0] got;
    logic [31:0] wval;
    int          lat;
    int          settle;
    logic [31:0] addr_a = 32'h0000_1234;
    logic [31:0] addr_b = 32'h0000_1274;
    logic [31:0] flush_addr [4] = '{32'h0000_2000, 32'h0000_300c, 32'h0000_401c, 32'h0000_300c};

    // memory traffic seen at the AXI-lite pins
    int          cycle = 0;
    int          ar_count = 0;
    int          ar_cycles = 0;
    int          ar_rise_cycle = 0;
    int          b_cycle = 0;
    logic        arvalid_q = 1'b0;
    logic [31:0] last_araddr = '0;
    logic [31:0] aw_addr_q [$];
    logic [31:0] w_data_q [$];

    // memory contents as the CPU writes imply them
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    dcache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush     (flush),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .flushing  (flushing),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid)
    );

    axi_mem_model #(.SEED(SEED)) u_mem (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid)
    );

    always @(posedge clk) begin
        if (arvalid) ar_cycles++;
        if (arvalid && !arvalid_q) ar_rise_cycle = cycle;
        if (arvalid && arready) begin
            ar_count++;
            last_araddr = araddr;
        end
        if (awvalid && awready) aw_addr_q.push_back(awaddr);
        if (wvalid && wready) w_data_q.push_back(wdata);
        if (bvalid) b_cycle = cycle;
        arvalid_q = arvalid;
        cycle++;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (exp_addr[i] == addr) return exp_data[i];
        end
        return addr ^ INIT_XOR;
    endfunction

    task automatic note_write(input logic [31:0] addr, input logic [31:0] data);
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (exp_addr[i] == addr) begin
                exp_data[i] = data;
                return;
            end
        end
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic clear_traffic();
        ar_count      = 0;
        ar_cycles     = 0;
        ar_rise_cycle = 0;
        b_cycle       = 0;
        aw_addr_q.delete();
        w_data_q.delete();
    endtask

    // every write transfer must carry the data the CPU last wrote there
    task automatic check_writes(input int count);
        check_value("write address transfers", count, aw_addr_q.size());
        check_value("write data transfers", count, w_data_q.size());
        for (int i = 0; i < aw_addr_q.size() && i < w_data_q.size(); i++) begin
            check_value("write-back data", expected_word(aw_addr_q[i]), w_data_q[i]);
        end
    endtask

    task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata_out, output int cycles);
        cycles    = 0;
        rdata_out = '0;
        @(posedge clk);
        #2;
        cpu_valid = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(posedge clk);
        #2;
        cpu_valid = 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ready && cycles < WAIT_LIMIT);
        rdata_out = cpu_rdata;
        assert (cpu_ready) else begin
            $display("%s: no cpu_ready within %0d cycles of the request", test_name, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic flush_all();
        int cycles;
        cycles = 1;
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        assert (flushing) else begin
            $display("%s: flushing did not rise in the cycle after flush", test_name);
            errors++;
        end
        while (!cpu_ready && cycles < FLUSH_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (cpu_ready && flushing) else begin
            $display("%s: flush did not end within %0d cycles", test_name, FLUSH_LIMIT);
            errors++;
        end
        @(negedge clk);
        assert (!flushing) else begin
            $display("%s: flushing stayed high after the closing cpu_ready", test_name);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        clear_traffic();
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        cpu_valid = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        flush     = 1'b0;
        rnd       = SEED;
        settle    = 0;
        while (!rst && settle < 50) begin
            @(posedge clk);
            settle++;
        end
        assert (rst) else begin
            $display("reset was never released");
            errors++;
        end

        begin_test("clean_read_miss");
        cpu_access(1'b0, addr_a, '0, got, lat);
        check_value("read data", addr_a ^ INIT_XOR, got);
        check_value("read address transfers", 1, ar_count);
        check_value("read address", addr_a, last_araddr);
        end_test();

        begin_test("read_hit");
        cpu_access(1'b0, addr_a, '0, got, lat);
        check_value("hit latency", 1, lat);
        check_value("read data", addr_a ^ INIT_XOR, got);
        check_value("arvalid cycles", 0, ar_cycles);
        end_test();

        begin_test("write_hit_read");
        rnd  = next_random(rnd);
        wval = rnd;
        cpu_access(1'b1, addr_a, wval, got, lat);
        note_write(addr_a, wval);
        check_value("write latency", 1, lat);
        cpu_access(1'b0, addr_a, '0, got, lat);
        check_value("read data", wval, got);
        check_value("arvalid cycles", 0, ar_cycles);
        check_value("write transfers", 0, aw_addr_q.size());
        end_test();

        begin_test("dirty_eviction");
        cpu_access(1'b0, addr_b, '0, got, lat);
        check_value("refill data", addr_b ^ INIT_XOR, got);
        check_writes(1);
        if (aw_addr_q.size() > 0) check_value("victim address", addr_a, aw_addr_q[0]);
        check_value("read address transfers", 1, ar_count);
        assert (b_cycle != 0 && b_cycle < ar_rise_cycle) else begin
            $display("%s: refill read address was not issued after the write response",
                     test_name);
            errors++;
        end
        end_test();

        begin_test("flush");
        foreach (flush_addr[i]) begin
            rnd = next_random(rnd);
            cpu_access(1'b1, flush_addr[i], rnd, got, lat);
            note_write(flush_addr[i], rnd);
        end
        clear_traffic();
        flush_all();
        // three distinct dirty lines, the clean refill of addr_b stays quiet
        check_writes(3);
        foreach (exp_addr[i]) begin
            check_value("memory contents", exp_data[i], u_mem.read_word(exp_addr[i]));
        end
        end_test();

        begin_test("flush_again");
        flush_all();
        check_writes(0);
        clear_traffic();
        cpu_access(1'b0, flush_addr[0], '0, got, lat);
        check_value("read data after flush", expected_word(flush_addr[0]), got);
        check_value("read address transfers", 1, ar_count);
        assert (lat > 1) else begin
            $display("%s: read of a flushed line answered as a hit", test_name);
            errors++;
        end
        end_test();

        repeat (4) @(posedge clk);
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release away from the clock edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
    end

endmodule
